/* Bender.yml */
package:
  name: zx_io

sources:
  - hdl/zx_ports_pkg.sv
  - hdl/zx_int_pkg.sv
  - hdl/zbus_sync.sv
  - hdl/port_regs.sv
  - hdl/int_ctrl.sv
  - hdl/sound_mix.sv
  - hdl/zx_io_top.sv
  - target: test
    files:
      - verification/tb_zx_io.sv

/* flist.f */
hdl/zx_ports_pkg.sv
hdl/zx_int_pkg.sv
hdl/zbus_sync.sv
hdl/port_regs.sv
hdl/int_ctrl.sv
hdl/sound_mix.sv
hdl/zx_io_top.sv
verification/tb_zx_io.sv

/* hdl/int_ctrl.sv */
`timescale 1ns/1ps

module int_ctrl import zx_ports_pkg::*, zx_int_pkg::*; (
  input  logic                 fclk,
  input  logic                 arst_n,
  input  logic                 int_start_frm,
  input  logic                 int_start_lin,
  input  logic [intmask_w-1:0] intmask,
  input  logic                 intack,
  input  logic                 intack_end,
  output logic                 int_n,
  output logic [data_w-1:0]    im2_vec,
  output logic                 im2_oe
);

  logic [1:0] pending;
  logic [1:0] start;
  logic [1:0] clr;
  logic       intack_q;
  logic       ack_frm;  // source taken by the running acknowledge
  logic       sel_frm;

  assign start[int_src_frm] = int_start_frm & intmask[int_src_frm];
  assign start[int_src_lin] = int_start_lin & intmask[int_src_lin];

  // only the acknowledged source is dropped
  assign clr[int_src_frm] = intack_end & ack_frm;
  assign clr[int_src_lin] = intack_end & ~ack_frm;

  always_ff @(posedge fclk or negedge arst_n) begin
    if (!arst_n) begin
      pending  <= '0;
      intack_q <= 1'b0;
      ack_frm  <= 1'b0;
    end else begin
      pending  <= (pending & ~clr) | start;  // new pulse wins over clear
      intack_q <= intack;
      if (intack && !intack_q) begin
        ack_frm <= pending[int_src_frm];
      end
    end
  end

  // frame outranks line, choice frozen after first intack cycle
  assign sel_frm = intack_q ? ack_frm : pending[int_src_frm];
  assign im2_vec = sel_frm ? vec_frm : vec_lin;
  assign im2_oe  = intack;
  assign int_n   = ~|pending;

  a_ack_after_int: assert property (@(posedge fclk) disable iff (!arst_n)
    im2_oe |-> $past(!int_n));

endmodule

/* hdl/port_regs.sv */
`timescale 1ns/1ps

module port_regs import zx_ports_pkg::*, zx_int_pkg::*; (
  input  logic                 fclk,
  input  logic                 arst_n,
  input  logic [15:0]          a,
  input  logic [data_w-1:0]    d_in,
  input  logic                 io_rd,
  input  logic                 io_wr_s,
  input  logic                 tape_in,
  input  logic [data_w-1:0]    im2_vec,
  input  logic                 im2_oe,
  output logic [data_w-1:0]    d_out,
  output logic                 d_oe,
  output logic [border_w-1:0]  border,
  output logic [intmask_w-1:0] intmask,
  output logic                 beeper,
  output logic                 mic,
  output logic                 beeper_mux,
  output logic                 tape_sound,
  output logic [data_w-1:0]    covox_val,
  output logic                 covox_wr
);

  logic [sysconf_w-1:0] sysconf;
  logic [sync_len-1:0]  tape_sr;
  logic                 is_fe;
  logic                 is_covox;
  logic                 is_ext;
  logic                 rd_fe;
  logic                 rd_sysconf;
  logic                 rd_intmask;
  logic [data_w-1:0]    fe_rdata;

  assign is_fe    = (a[0] == port_fe_lo[0]);  // ula answers on any even port
  assign is_covox = (a[7:0] == port_covox_lo);
  assign is_ext   = (a[7:0] == port_ext_lo);

  assign beeper_mux = sysconf[cfg_beeper_mux_bit];
  assign tape_sound = sysconf[cfg_tape_sound_bit];

  always_ff @(posedge fclk or negedge arst_n) begin
    if (!arst_n) begin
      border   <= '0;
      sysconf  <= sysconf_rst;
      intmask  <= intmask_rst;
      beeper   <= 1'b0;
      mic      <= 1'b0;
      covox_wr <= 1'b0;
      tape_sr  <= '0;
    end else begin
      covox_wr <= 1'b0;
      tape_sr  <= {tape_sr[sync_len-2:0], tape_in};
      if (io_wr_s) begin
        if (is_fe) begin
          border <= {{(border_w-3){1'b0}}, d_in[2:0]};  // spectrum colours only
          beeper <= d_in[fe_beeper_bit];
          mic    <= d_in[fe_mic_bit];
        end
        if (is_covox) begin
          covox_wr <= 1'b1;
        end
        if (is_ext) begin
          case (a[15:8])
            reg_border_hi:  border  <= d_in[border_w-1:0];
            reg_sysconf_hi: sysconf <= d_in[sysconf_w-1:0];
            reg_intmask_hi: intmask <= d_in[intmask_w-1:0];
            default: ;  // unknown selectors ignored
          endcase
        end
      end
    end
  end

  always_ff @(posedge fclk) begin
    if (io_wr_s && is_covox) begin
      covox_val <= d_in;
    end
  end

  // read side
  assign rd_fe      = io_rd & is_fe;
  assign rd_sysconf = io_rd & is_ext & (a[15:8] == reg_sysconf_hi);
  assign rd_intmask = io_rd & is_ext & (a[15:8] == reg_intmask_hi);

  always_comb begin
    fe_rdata = '1;
    fe_rdata[fe_tape_bit] = tape_sr[sync_len-1];
  end

  always_comb begin
    d_out = '1;
    if (im2_oe) begin
      d_out = im2_vec;  // vector wins over any port read
    end else if (rd_fe) begin
      d_out = fe_rdata;
    end else if (rd_sysconf) begin
      d_out = sysconf;
    end else if (rd_intmask) begin
      d_out = intmask;
    end
  end

  assign d_oe = im2_oe | rd_fe | rd_sysconf | rd_intmask;

  // bus stays released while a write is taken
  a_oe_src: assert property (@(posedge fclk) disable iff (!arst_n)
    io_wr_s |-> !d_oe);

endmodule

/* hdl/sound_mix.sv */
`timescale 1ns/1ps

module sound_mix import zx_ports_pkg::*; (
  input  logic              fclk,
  input  logic              arst_n,
  input  logic              beeper,
  input  logic              mic,
  input  logic              beeper_mux,
  input  logic              tape_sound,
  input  logic              tape_in,
  input  logic [data_w-1:0] covox_val,
  input  logic              covox_wr,
  output logic              beep
);

  logic [sync_len-1:0] tape_sr;
  logic                beeper_q;
  logic                mic_q;
  logic                covox_mode;
  logic [data_w-1:0]   covox_lat;
  logic [data_w-1:0]   acc;
  logic [data_w:0]     acc_sum;
  logic                beep_bit;
  logic                beep_chg;

  assign acc_sum  = {1'b0, acc} + {1'b0, covox_lat};  // carry is the pwm bit
  assign beep_chg = (beeper != beeper_q) | (mic != mic_q);
  assign beep_bit = (beeper_mux ? mic : beeper) ^ (tape_sound & tape_sr[sync_len-1]);

  always_ff @(posedge fclk) begin
    if (covox_wr) begin
      covox_lat <= covox_val;
    end
  end

  always_ff @(posedge fclk or negedge arst_n) begin
    if (!arst_n) begin
      tape_sr    <= '0;
      beeper_q   <= 1'b0;
      mic_q      <= 1'b0;
      covox_mode <= 1'b0;
      acc        <= '0;
      beep       <= 1'b0;
    end else begin
      tape_sr  <= {tape_sr[sync_len-2:0], tape_in};
      beeper_q <= beeper;
      mic_q    <= mic;
      if (covox_wr) begin
        covox_mode <= 1'b1;
        acc        <= '0;
      end else begin
        if (beep_chg) begin
          covox_mode <= 1'b0;  // back to beeper on any #FE sound change
        end
        if (covox_mode) begin
          acc <= acc_sum[data_w-1:0];
        end
      end
      beep <= covox_mode ? acc_sum[data_w] : beep_bit;
    end
  end

endmodule

/* hdl/zbus_sync.sv */
`timescale 1ns/1ps

module zbus_sync import zx_ports_pkg::*; (
  input  logic fclk,
  input  logic arst_n,
  input  logic iorq_n,
  input  logic mreq_n,
  input  logic rd_n,
  input  logic wr_n,
  input  logic m1_n,
  output logic io_rd,
  output logic io_wr_s,
  output logic intack,
  output logic intack_end
);

  // synchronisers hold active-high copies of the strobes
  logic [sync_len-1:0] iorq_sr;
  logic [sync_len-1:0] mreq_sr;
  logic [sync_len-1:0] rd_sr;
  logic [sync_len-1:0] wr_sr;
  logic [sync_len-1:0] m1_sr;
  logic iorq;
  logic mreq;
  logic rd;
  logic wr;
  logic m1;
  logic io_wr;
  logic io_wr_q;
  logic intack_q;

  always_ff @(posedge fclk or negedge arst_n) begin
    if (!arst_n) begin
      iorq_sr <= '0;
      mreq_sr <= '0;
      rd_sr   <= '0;
      wr_sr   <= '0;
      m1_sr   <= '0;
    end else begin
      iorq_sr <= {iorq_sr[sync_len-2:0], ~iorq_n};
      mreq_sr <= {mreq_sr[sync_len-2:0], ~mreq_n};
      rd_sr   <= {rd_sr[sync_len-2:0], ~rd_n};
      wr_sr   <= {wr_sr[sync_len-2:0], ~wr_n};
      m1_sr   <= {m1_sr[sync_len-2:0], ~m1_n};
    end
  end

  assign iorq = iorq_sr[sync_len-1];
  assign mreq = mreq_sr[sync_len-1];
  assign rd   = rd_sr[sync_len-1];
  assign wr   = wr_sr[sync_len-1];
  assign m1   = m1_sr[sync_len-1];

  assign io_rd  = iorq & rd & ~m1;
  assign io_wr  = iorq & wr;
  assign intack = iorq & m1 & ~mreq;  // mreq low means an opcode fetch

  always_ff @(posedge fclk or negedge arst_n) begin
    if (!arst_n) begin
      io_wr_q  <= 1'b0;
      intack_q <= 1'b0;
    end else begin
      io_wr_q  <= io_wr;
      intack_q <= intack;
    end
  end

  assign io_wr_s    = io_wr & ~io_wr_q;     // one pulse per write cycle
  assign intack_end = intack_q & ~intack;

  // a write strobe never overlaps rd or m1 on the bus
  a_wr_pulse: assert property (@(posedge fclk) disable iff (!arst_n)
    io_wr_s |-> (!rd && !m1));

endmodule

/* hdl/zx_int_pkg.sv */
package zx_int_pkg;

  // pending bit index per source
  localparam int int_src_frm = 0;
  localparam int int_src_lin = 1;

  localparam int intmask_w = 8;  // bits 7:2 reserved

  // frame only after reset
  localparam logic [intmask_w-1:0] intmask_rst = 8'h01;

  // im2 vectors put on the bus during intack
  localparam logic [7:0] vec_frm = 8'hFF;
  localparam logic [7:0] vec_lin = 8'hFD;

endpackage

/* hdl/zx_io_top.sv */
`timescale 1ns/1ps

module zx_io_top (
  input  logic        fclk,
  input  logic        arst_n,
  input  logic        iorq_n,
  input  logic        mreq_n,
  input  logic        rd_n,
  input  logic        wr_n,
  input  logic        m1_n,
  input  logic [15:0] a,
  input  logic [7:0]  d_in,
  input  logic        int_start_frm,
  input  logic        int_start_lin,
  input  logic        tape_in,
  output logic [7:0]  d_out,
  output logic        d_oe,
  output logic        int_n,
  output logic [7:0]  border,
  output logic        beep
);

  logic       io_rd;
  logic       io_wr_s;
  logic       intack;
  logic       intack_end;
  logic [7:0] intmask;
  logic       beeper;
  logic       mic;
  logic       beeper_mux;
  logic       tape_sound;
  logic [7:0] covox_val;
  logic       covox_wr;
  logic [7:0] im2_vec;
  logic       im2_oe;

  zbus_sync sync_i (
    .fclk       (fclk),
    .arst_n     (arst_n),
    .iorq_n     (iorq_n),
    .mreq_n     (mreq_n),
    .rd_n       (rd_n),
    .wr_n       (wr_n),
    .m1_n       (m1_n),
    .io_rd      (io_rd),
    .io_wr_s    (io_wr_s),
    .intack     (intack),
    .intack_end (intack_end)
  );

  port_regs regs_i (
    .fclk       (fclk),
    .arst_n     (arst_n),
    .a          (a),
    .d_in       (d_in),
    .io_rd      (io_rd),
    .io_wr_s    (io_wr_s),
    .tape_in    (tape_in),
    .im2_vec    (im2_vec),
    .im2_oe     (im2_oe),
    .d_out      (d_out),
    .d_oe       (d_oe),
    .border     (border),
    .intmask    (intmask),
    .beeper     (beeper),
    .mic        (mic),
    .beeper_mux (beeper_mux),
    .tape_sound (tape_sound),
    .covox_val  (covox_val),
    .covox_wr   (covox_wr)
  );

  int_ctrl int_i (
    .fclk          (fclk),
    .arst_n        (arst_n),
    .int_start_frm (int_start_frm),
    .int_start_lin (int_start_lin),
    .intmask       (intmask),
    .intack        (intack),
    .intack_end    (intack_end),
    .int_n         (int_n),
    .im2_vec       (im2_vec),
    .im2_oe        (im2_oe)
  );

  sound_mix snd_i (
    .fclk       (fclk),
    .arst_n     (arst_n),
    .beeper     (beeper),
    .mic        (mic),
    .beeper_mux (beeper_mux),
    .tape_sound (tape_sound),
    .tape_in    (tape_in),
    .covox_val  (covox_val),
    .covox_wr   (covox_wr),
    .beep       (beep)
  );

endmodule

/* hdl/zx_ports_pkg.sv */
package zx_ports_pkg;

  localparam int data_w   = 8;
  localparam int sync_len = 2;  // flops per synchroniser

  // low address bytes
  localparam logic [7:0] port_fe_lo    = 8'hFE;  // only bit 0 is decoded
  localparam logic [7:0] port_covox_lo = 8'hFB;
  localparam logic [7:0] port_ext_lo   = 8'hAF;

  // extended register selectors, taken from a[15:8]
  localparam logic [7:0] reg_border_hi  = 8'h0F;
  localparam logic [7:0] reg_sysconf_hi = 8'h20;
  localparam logic [7:0] reg_intmask_hi = 8'h2A;

  localparam int border_w  = 8;
  localparam int sysconf_w = 8;

  // sysconf bits
  localparam int cfg_beeper_mux_bit = 3;  // 1 selects mic
  localparam int cfg_tape_sound_bit = 7;

  // #FE data bits
  localparam int fe_beeper_bit = 4;
  localparam int fe_mic_bit    = 3;
  localparam int fe_tape_bit   = 6;  // read side

  localparam logic [sysconf_w-1:0] sysconf_rst = '0;

endpackage

/* verification/tb_zx_io.sv */
`timescale 1ns/1ps

module tb_zx_io import zx_ports_pkg::*, zx_int_pkg::*; ();

  localparam int wait_limit = 32;  // cycles per wait loop

  localparam logic [15:0] addr_fe      = {8'h7F, port_fe_lo};
  localparam logic [15:0] addr_covox   = {8'h00, port_covox_lo};
  localparam logic [15:0] addr_border  = {reg_border_hi, port_ext_lo};
  localparam logic [15:0] addr_sysconf = {reg_sysconf_hi, port_ext_lo};
  localparam logic [15:0] addr_intmask = {reg_intmask_hi, port_ext_lo};

  logic        fclk;
  logic        arst_n;
  logic        iorq_n;
  logic        mreq_n;
  logic        rd_n;
  logic        wr_n;
  logic        m1_n;
  logic [15:0] a;
  logic [7:0]  d_in;
  logic        int_start_frm;
  logic        int_start_lin;
  logic        tape_in;
  logic [7:0]  d_out;
  logic        d_oe;
  logic        int_n;
  logic [7:0]  border;
  logic        beep;

  logic [31:0] lfsr;
  int          mismatches;
  int          timeouts;
  logic [7:0]  val;
  logic [7:0]  v_sys;
  logic [7:0]  v_mask;

  zx_io_top dut_i (
    .fclk          (fclk),
    .arst_n        (arst_n),
    .iorq_n        (iorq_n),
    .mreq_n        (mreq_n),
    .rd_n          (rd_n),
    .wr_n          (wr_n),
    .m1_n          (m1_n),
    .a             (a),
    .d_in          (d_in),
    .int_start_frm (int_start_frm),
    .int_start_lin (int_start_lin),
    .tape_in       (tape_in),
    .d_out         (d_out),
    .d_oe          (d_oe),
    .int_n         (int_n),
    .border        (border),
    .beep          (beep)
  );

  initial begin
    fclk = 1'b0;
    forever #4 fclk = ~fclk;
  end

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic rand_byte(output logic [7:0] b);
    b = '0;
    repeat (8) begin
      lfsr = lfsr_next(lfsr);
      b = {b[6:0], lfsr[0]};
    end
  endtask

  task automatic report_mismatch(input string name, input logic [15:0] exp,
                                 input logic [15:0] got);
    mismatches++;
    $display("Fail at %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, exp, got);
  endtask

  task automatic wait_d_oe(input logic level);
    int n;
    n = 0;
    @(negedge fclk);
    while (d_oe !== level && n < wait_limit) begin
      @(negedge fclk);
      n++;
    end
    if (d_oe !== level) begin
      timeouts++;
      $display("Timeout at %0t ns: d_oe never went to %0b", $time, level);
    end
  endtask

  task automatic wait_int_n(input logic level);
    int n;
    n = 0;
    @(negedge fclk);
    while (int_n !== level && n < wait_limit) begin
      @(negedge fclk);
      n++;
    end
    if (int_n !== level) begin
      timeouts++;
      $display("Timeout at %0t ns: int_n never went to %0b", $time, level);
    end
  endtask

  task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
    @(posedge fclk);
    a      <= addr;
    d_in   <= data;
    iorq_n <= 1'b0;
    wr_n   <= 1'b0;
    repeat (3) @(posedge fclk);  // synchroniser plus the write edge
    iorq_n <= 1'b1;
    wr_n   <= 1'b1;
    repeat (2) @(posedge fclk);
  endtask

  task automatic io_read_check(input logic [15:0] addr, input logic [7:0] exp);
    @(posedge fclk);
    a      <= addr;
    iorq_n <= 1'b0;
    rd_n   <= 1'b0;
    wait_d_oe(1'b1);
    if (d_out !== exp) report_mismatch("d_out", exp, d_out);
    @(posedge fclk);
    iorq_n <= 1'b1;
    rd_n   <= 1'b1;
    wait_d_oe(1'b0);
  endtask

  task automatic int_ack_check(input logic [7:0] vec, input logic int_n_after);
    @(posedge fclk);
    iorq_n <= 1'b0;
    m1_n   <= 1'b0;  // mreq_n stays high
    wait_d_oe(1'b1);
    if (d_out !== vec) report_mismatch("d_out", vec, d_out);
    @(posedge fclk);
    iorq_n <= 1'b1;
    m1_n   <= 1'b1;
    wait_d_oe(1'b0);
    repeat (4) @(negedge fclk);
    if (int_n !== int_n_after) report_mismatch("int_n", int_n_after, int_n);
  endtask

  task automatic pulse_int(input logic frm, input logic lin);
    @(posedge fclk);
    int_start_frm <= frm;
    int_start_lin <= lin;
    @(posedge fclk);
    int_start_frm <= 1'b0;
    int_start_lin <= 1'b0;
  endtask

  task automatic expect_beep(input logic exp);
    repeat (6) @(posedge fclk);
    @(negedge fclk);
    if (beep !== exp) report_mismatch("beep", exp, beep);
  endtask

  task automatic expect_border(input logic [7:0] exp);
    repeat (6) @(posedge fclk);
    @(negedge fclk);
    if (border !== exp) report_mismatch("border", exp, border);
  endtask

  // any 256 cycle window holds exactly v high cycles
  task automatic count_beep(input logic [7:0] v);
    int high;
    high = 0;
    repeat (4) @(posedge fclk);
    repeat (256) begin
      @(negedge fclk);
      if (beep === 1'b1) high++;
    end
    if (high != v) report_mismatch("beep high cycles", v, high);
  endtask

  initial begin
    arst_n        = 1'b0;
    iorq_n        = 1'b1;
    mreq_n        = 1'b1;
    rd_n          = 1'b1;
    wr_n          = 1'b1;
    m1_n          = 1'b1;
    a             = '0;
    d_in          = '0;
    int_start_frm = 1'b0;
    int_start_lin = 1'b0;
    tape_in       = 1'b0;
    lfsr          = 32'h25c8;
    mismatches    = 0;
    timeouts      = 0;
    repeat (16) @(posedge fclk);
    arst_n <= 1'b1;
    repeat (2) @(posedge fclk);
    @(negedge fclk);

    // reset values
    if (int_n !== 1'b1) report_mismatch("int_n", 1'b1, int_n);
    if (d_oe !== 1'b0) report_mismatch("d_oe", 1'b0, d_oe);
    if (beep !== 1'b0) report_mismatch("beep", 1'b0, beep);
    if (border !== 8'h00) report_mismatch("border", 8'h00, border);
    io_read_check(addr_intmask, 8'h01);
    io_read_check(addr_sysconf, 8'h00);

    // register writes
    rand_byte(val);
    io_write(addr_border, val);
    expect_border(val);
    rand_byte(v_sys);
    io_write(addr_sysconf, v_sys);
    rand_byte(v_mask);
    io_write(addr_intmask, v_mask);
    io_read_check(addr_sysconf, v_sys);
    io_read_check(addr_intmask, v_mask);
    rand_byte(val);
    io_write(addr_fe, val);
    expect_border({5'b0, val[2:0]});
    @(posedge fclk);
    tape_in <= 1'b1;
    repeat (4) @(posedge fclk);
    io_read_check(addr_fe, 8'hFF);
    @(posedge fclk);
    tape_in <= 1'b0;
    repeat (4) @(posedge fclk);
    io_read_check(addr_fe, 8'hBF);

    // beeper path
    io_write(addr_sysconf, 8'h00);
    io_write(addr_fe, 8'h10);
    expect_beep(1'b1);
    io_write(addr_fe, 8'h00);
    expect_beep(1'b0);
    io_write(addr_sysconf, 8'h08);  // mic selected
    io_write(addr_fe, 8'h08);
    expect_beep(1'b1);
    io_write(addr_fe, 8'h10);
    expect_beep(1'b0);
    io_write(addr_sysconf, 8'h80);  // tape mixed in
    io_write(addr_fe, 8'h10);
    expect_beep(1'b1);
    @(posedge fclk);
    tape_in <= 1'b1;
    expect_beep(1'b0);
    @(posedge fclk);
    tape_in <= 1'b0;
    expect_beep(1'b1);
    io_write(addr_sysconf, 8'h00);

    // covox
    repeat (4) begin
      rand_byte(val);
      io_write(addr_covox, val);
      count_beep(val);
    end

    // masking, line disabled
    io_write(addr_intmask, 8'h01);
    pulse_int(1'b0, 1'b1);
    repeat (6) begin
      @(negedge fclk);
      if (int_n !== 1'b1) report_mismatch("int_n", 1'b1, int_n);
    end
    pulse_int(1'b1, 1'b0);
    wait_int_n(1'b0);
    int_ack_check(vec_frm, 1'b1);

    // priority
    io_write(addr_intmask, 8'h03);
    pulse_int(1'b1, 1'b1);
    wait_int_n(1'b0);
    int_ack_check(vec_frm, 1'b0);
    int_ack_check(vec_lin, 1'b1);

    $display("mismatches: %0d, timeouts: %0d", mismatches, timeouts);
    if (mismatches == 0 && timeouts == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule
